//--- hdl/vldu_pkg.sv
//--------------------
// Two lanes of 64 bits fed by 8-byte read beats
// A load must not exceed MaxVlBytes bytes (vl shifted left by vsew)
//--------------------
package vldu_pkg;

  // Datapath geometry
  localparam int unsigned NrLanes   = 2;
  localparam int unsigned ElenBits  = 64;
  localparam int unsigned LaneBytes = ElenBits / 8;
  localparam int unsigned WordBytes = NrLanes * LaneBytes;
  localparam int unsigned BeatBytes = 8;

  // Queue depths, both powers of two
  localparam int unsigned VInsnQueueDepth  = 4;
  localparam int unsigned ResultQueueDepth = 2;

  // Instruction ids and register layout
  localparam int unsigned NrVInsn    = 8;
  localparam int unsigned VRegWords  = 16;
  localparam int unsigned MaxVlBytes = 256;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [4:0]                 vreg_t;
  typedef logic [8:0]                 vlen_t;
  typedef logic [8:0]                 vaddr_t;
  typedef logic [ElenBits-1:0]        elen_t;
  typedef logic [LaneBytes-1:0]       strb_t;
  typedef logic [8*BeatBytes-1:0]     beat_t;

  // Element width, 2**code bytes
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vsew_e;

  // Load request from the sequencer
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vlen_t vl;
    vsew_e vsew;
  } ld_req_t;

  // One lane write towards the VRF
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_word_t;

  // Lane that owns sequential byte b
  function automatic int unsigned shuffle_lane(int unsigned b, vsew_e s);
    int unsigned e;
    e = b >> s;
    return e % NrLanes;
  endfunction

  // Byte position of sequential byte b inside its lane word
  function automatic int unsigned shuffle_offset(int unsigned b, vsew_e s);
    int unsigned e;
    int unsigned k;
    e = b >> s;
    k = b & ((1 << s) - 1);
    return (((e / NrLanes) << s) + k) % LaneBytes;
  endfunction

  // Lane-local address of word idx of register vd
  function automatic vaddr_t lane_word_addr(vreg_t vd, logic [$clog2(VRegWords)-1:0] idx);
    return vaddr_t'(vd * VRegWords + idx);
  endfunction

endpackage

//--- hdl/vldu_ring_fifo.sv
//--------------------
// Depth fixed by VInsnQueueDepth, a power of two
// Push when full or pop when empty is not guarded
//--------------------
`timescale 1ns/1ps

module vldu_ring_fifo import vldu_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PtrW = $clog2(VInsnQueueDepth);

  // Storage, written at the write pointer
  payload_t        mem_q [VInsnQueueDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  // Occupancy, one bit wider than the pointers
  logic [PtrW:0]   cnt_q;

  assign head_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == (PtrW+1)'(VInsnQueueDepth));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap on their own
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      // Simultaneous push and pop keep the count
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- hdl/vldu_insn_tracker.sv
//--------------------
// Holds up to VInsnQueueDepth loads; an id is refused while it runs
// Done bits are registered one-cycle pulses, in acceptance order
//--------------------
`timescale 1ns/1ps

module vldu_insn_tracker import vldu_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ld_req_t            pe_req_i,
  input  logic               pe_req_valid_i,
  output logic               pe_req_ready_o,
  output ld_req_t            issue_req_o,
  output logic               issue_valid_o,
  input  logic               issue_done_i,
  input  logic               word_commit_i,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  // Commit side only needs id, length and width
  typedef struct packed {
    vid_t  id;
    vlen_t vl;
    vsew_e vsew;
  } commit_rec_t;

  logic               started_q;
  logic [NrVInsn-1:0] running_q;
  logic [NrVInsn-1:0] running_d;
  logic               accept;
  logic               issue_empty;
  commit_rec_t        commit_rec;
  commit_rec_t        commit_head;
  logic               commit_empty;
  logic               commit_full;
  logic               commit_pop;
  // Remaining elements of the commit head
  vlen_t              commit_cnt_q;
  vlen_t              commit_cnt_d;
  vlen_t              cur_cnt;
  vlen_t              word_elems;
  logic               cnt_loaded_q;
  logic               cnt_loaded_d;
  logic [NrVInsn-1:0] done_d;

  // Hold off the first cycle out of reset
  assign pe_req_ready_o = started_q && !commit_full && !running_q[pe_req_i.id];
  assign accept         = pe_req_valid_i && pe_req_ready_o;
  assign issue_valid_o  = !issue_empty;
  assign commit_rec     = '{id: pe_req_i.id, vl: pe_req_i.vl, vsew: pe_req_i.vsew};

  // Issue side, popped when the packer finishes an instruction
  vldu_ring_fifo #(.payload_t(ld_req_t)) issue_fifo_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (accept),
    .data_i  (pe_req_i),
    .pop_i   (issue_done_i),
    .head_o  (issue_req_o),
    .empty_o (issue_empty),
    // Never fuller than the commit side
    .full_o  ()
  );

  // Commit side, popped when the last word is written
  vldu_ring_fifo #(.payload_t(commit_rec_t)) commit_fifo_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (accept),
    .data_i  (commit_rec),
    .pop_i   (commit_pop),
    .head_o  (commit_head),
    .empty_o (commit_empty),
    .full_o  (commit_full)
  );

  always_comb begin
    // Fresh head starts from its full length
    cur_cnt      = cnt_loaded_q ? commit_cnt_q : commit_head.vl;
    word_elems   = vlen_t'(NrLanes * (8 >> commit_head.vsew));
    commit_cnt_d = cur_cnt;
    if (word_commit_i) begin
      commit_cnt_d = (cur_cnt > word_elems) ? cur_cnt - word_elems : '0;
    end
    commit_pop   = !commit_empty && (commit_cnt_d == '0);
    cnt_loaded_d = !commit_empty && !commit_pop;
    done_d       = '0;
    running_d    = running_q;
    if (commit_pop) begin
      done_d[commit_head.id]    = 1'b1;
      running_d[commit_head.id] = 1'b0;
    end
    // Accepted id is never the finishing one
    if (accept) running_d[pe_req_i.id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q    <= 1'b0;
      running_q    <= '0;
      commit_cnt_q <= '0;
      cnt_loaded_q <= 1'b0;
      vinsn_done_o <= '0;
    end else begin
      started_q    <= 1'b1;
      running_q    <= running_d;
      commit_cnt_q <= commit_cnt_d;
      cnt_loaded_q <= cnt_loaded_d;
      vinsn_done_o <= done_d;
    end
  end

endmodule

//--- hdl/vldu_beat_packer.sv
//--------------------
// Every beat is fully valid from byte 0 and belongs to one load only
// WordBytes must be a multiple of BeatBytes; pushes wait for result queue room
//--------------------
`timescale 1ns/1ps

module vldu_beat_packer import vldu_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  beat_t                        r_data_i,
  input  logic                         r_valid_i,
  output logic                         r_ready_o,
  input  ld_req_t                      issue_req_i,
  input  logic                         issue_valid_i,
  output logic                         issue_done_o,
  input  logic                         rq_full_i,
  output logic                         word_push_o,
  output lane_word_t [NrLanes-1:0]     word_o
);

  localparam int unsigned BytesW  = $clog2(MaxVlBytes) + 1;
  localparam int unsigned VrfPntW = $clog2(WordBytes);

  // Next sequential byte in the VRF word
  logic [VrfPntW-1:0]           vrf_pnt_q, vrf_pnt_d;
  // Bytes still owed to the issue head
  logic [BytesW-1:0]            left_q, left_d, cur_left;
  logic                         loaded_q, loaded_d;
  logic [$clog2(VRegWords)-1:0] word_idx_q, word_idx_d;
  // Word under assembly
  elen_t [NrLanes-1:0]          wdata_q, wdata_d;
  strb_t [NrLanes-1:0]          be_q, be_d, be_word;
  logic                         act;

  always_comb begin
    int unsigned take;
    int unsigned seq;
    int unsigned lane;
    int unsigned off;
    int unsigned new_vrf;
    take    = 0;
    seq     = 0;
    lane    = 0;
    off     = 0;
    new_vrf = vrf_pnt_q;
    // Length in bytes until the head is first touched
    cur_left     = loaded_q ? left_q : BytesW'(issue_req_i.vl << issue_req_i.vsew);
    vrf_pnt_d    = vrf_pnt_q;
    left_d       = left_q;
    loaded_d     = loaded_q;
    word_idx_d   = word_idx_q;
    wdata_d      = wdata_q;
    be_word      = be_q;
    r_ready_o    = 1'b0;
    word_push_o  = 1'b0;
    issue_done_o = 1'b0;

    // Need a beat, a load and room downstream
    act = r_valid_i && issue_valid_i && !rq_full_i && (cur_left != '0);

    if (act) begin
      // Whole beat, or the tail of the load
      take = BeatBytes;
      if (cur_left < take) take = cur_left;
      for (int i = 0; i < BeatBytes; i++) begin
        if (i < take) begin
          // Word starts are lane aligned, so the in-word index shuffles alike
          seq  = vrf_pnt_q + i;
          lane = shuffle_lane(seq, issue_req_i.vsew);
          off  = shuffle_offset(seq, issue_req_i.vsew);
          wdata_d[lane][8*off +: 8] = r_data_i[8*i +: 8];
          be_word[lane][off]        = 1'b1;
        end
      end
      new_vrf   = vrf_pnt_q + take;
      left_d    = cur_left - BytesW'(take);
      loaded_d  = 1'b1;
      vrf_pnt_d = VrfPntW'(new_vrf);
      // Full word or tail of the load
      if (new_vrf == WordBytes || left_d == '0) begin
        word_push_o = 1'b1;
        vrf_pnt_d   = '0;
        word_idx_d  = word_idx_q + 1'b1;
      end
      // Beat used up, or rest of it dropped
      r_ready_o = 1'b1;
      if (left_d == '0) begin
        issue_done_o = 1'b1;
        loaded_d     = 1'b0;
        word_idx_d   = '0;
      end
    end else if (issue_valid_i && cur_left == '0) begin
      // Empty load retires without data
      issue_done_o = 1'b1;
      loaded_d     = 1'b0;
    end

    be_d = word_push_o ? '0 : be_word;
  end

  // Same register address in every lane
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      word_o[l].id    = issue_req_i.id;
      word_o[l].addr  = lane_word_addr(issue_req_i.vd, word_idx_q);
      word_o[l].wdata = wdata_d[l];
      word_o[l].be    = be_word[l];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vrf_pnt_q  <= '0;
      left_q     <= '0;
      loaded_q   <= 1'b0;
      word_idx_q <= '0;
      be_q       <= '0;
    end else begin
      vrf_pnt_q  <= vrf_pnt_d;
      left_q     <= left_d;
      loaded_q   <= loaded_d;
      word_idx_q <= word_idx_d;
      be_q       <= be_d;
    end
  end

  always_ff @(posedge clk_i) begin
    wdata_q <= wdata_d;
  end

endmodule

//--- hdl/vldu_result_queue.sv
//--------------------
// Each lane is written under its own request and grant
// Push only while full_o is low
//--------------------
`timescale 1ns/1ps

module vldu_result_queue import vldu_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     word_push_i,
  input  lane_word_t [NrLanes-1:0] word_i,
  output logic                     full_o,
  output logic                     word_commit_o,
  output logic       [NrLanes-1:0] ldu_req_o,
  output vid_t       [NrLanes-1:0] ldu_id_o,
  output vaddr_t     [NrLanes-1:0] ldu_addr_o,
  output elen_t      [NrLanes-1:0] ldu_wdata_o,
  output strb_t      [NrLanes-1:0] ldu_be_o,
  input  logic       [NrLanes-1:0] ldu_gnt_i
);

  localparam int unsigned PtrW = $clog2(ResultQueueDepth);

  lane_word_t [ResultQueueDepth-1:0][NrLanes-1:0] entry_q;
  // A lane stays pending until granted
  logic       [ResultQueueDepth-1:0][NrLanes-1:0] valid_q, valid_d;
  logic       [PtrW-1:0]                          wr_ptr_q;
  logic       [PtrW-1:0]                          rd_ptr_q;
  logic       [PtrW:0]                            cnt_q, cnt_d;

  assign full_o = (cnt_q == (PtrW+1)'(ResultQueueDepth));

  always_comb begin
    valid_d       = valid_q;
    cnt_d         = cnt_q;
    word_commit_o = 1'b0;

    // Head entry drives the lanes
    for (int l = 0; l < NrLanes; l++) begin
      ldu_req_o[l]   = valid_q[rd_ptr_q][l];
      ldu_id_o[l]    = entry_q[rd_ptr_q][l].id;
      ldu_addr_o[l]  = entry_q[rd_ptr_q][l].addr;
      ldu_wdata_o[l] = entry_q[rd_ptr_q][l].wdata;
      ldu_be_o[l]    = entry_q[rd_ptr_q][l].be;
      if (ldu_gnt_i[l] && valid_q[rd_ptr_q][l]) valid_d[rd_ptr_q][l] = 1'b0;
    end

    // Last pending lane granted, word retires
    if (cnt_q != '0 && valid_d[rd_ptr_q] == '0) begin
      word_commit_o = 1'b1;
      cnt_d         = cnt_d - 1'b1;
    end

    // New word lands in a free slot
    if (word_push_i) begin
      valid_d[wr_ptr_q] = '1;
      cnt_d             = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      cnt_q   <= cnt_d;
      if (word_push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (word_commit_o) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_push_i) entry_q[wr_ptr_q] <= word_i;
  end

endmodule

//--- hdl/vldu.sv
//--------------------
// Load unit only; every request is a unit-stride load
// Read beats must arrive in instruction order
//--------------------
`timescale 1ns/1ps

module vldu import vldu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer
  input  ld_req_t              pe_req_i,
  input  logic                 pe_req_valid_i,
  output logic                 pe_req_ready_o,
  output logic   [NrVInsn-1:0] vinsn_done_o,
  // Memory read data
  input  beat_t                r_data_i,
  input  logic                 r_valid_i,
  output logic                 r_ready_o,
  // Lanes
  output logic   [NrLanes-1:0] ldu_req_o,
  output vid_t   [NrLanes-1:0] ldu_id_o,
  output vaddr_t [NrLanes-1:0] ldu_addr_o,
  output elen_t  [NrLanes-1:0] ldu_wdata_o,
  output strb_t  [NrLanes-1:0] ldu_be_o,
  input  logic   [NrLanes-1:0] ldu_gnt_i
);

  ld_req_t                  issue_req;
  logic                     issue_valid;
  logic                     issue_done;
  logic                     word_push;
  lane_word_t [NrLanes-1:0] word;
  logic                     rq_full;
  logic                     word_commit;

  // Queues, running ids and done pulses
  vldu_insn_tracker tracker_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .issue_req_o    (issue_req),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .word_commit_i  (word_commit),
    .vinsn_done_o   (vinsn_done_o)
  );

  // Beats to shuffled lane words
  vldu_beat_packer packer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .r_data_i      (r_data_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .issue_req_i   (issue_req),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .rq_full_i     (rq_full),
    .word_push_o   (word_push),
    .word_o        (word)
  );

  // Per-lane VRF writes
  vldu_result_queue result_queue_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .word_push_i   (word_push),
    .word_i        (word),
    .full_o        (rq_full),
    .word_commit_o (word_commit),
    .ldu_req_o     (ldu_req_o),
    .ldu_id_o      (ldu_id_o),
    .ldu_addr_o    (ldu_addr_o),
    .ldu_wdata_o   (ldu_wdata_o),
    .ldu_be_o      (ldu_be_o),
    .ldu_gnt_i     (ldu_gnt_i)
  );

endmodule

//--- include/tb_vldu_ref.svh
//--------------------
// Included inside tb_vldu after its reference tables and abort task
// Expected words follow the byte shuffle rules, one instruction per table slot
//--------------------
`ifndef TB_VLDU_REF_SVH
`define TB_VLDU_REF_SVH

// 16-bit Galois LFSR, one step per bit
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  if (state[0]) return (state >> 1) ^ 16'hB400;
  return state >> 1;
endfunction

// Collect n random bits, LSB first
task automatic draw_bits(inout logic [15:0] state, input int unsigned n,
                         output logic [63:0] bits);
  bits = '0;
  for (int unsigned i = 0; i < n; i++) begin
    bits[i] = state[0];
    state   = lfsr_step(state);
  end
endtask

function automatic int unsigned load_bytes(input int unsigned seq);
  return insn_vl[seq] << insn_sew[seq];
endfunction

function automatic int unsigned word_count(input int unsigned seq);
  return (load_bytes(seq) + WordBytes - 1) / WordBytes;
endfunction

function automatic int unsigned beat_count(input int unsigned seq);
  return (load_bytes(seq) + BeatBytes - 1) / BeatBytes;
endfunction

// Lane l of word w of load seq; bytes without enable stay zero
function automatic lane_word_t expected_lane_word(input int unsigned seq,
                                                  input int unsigned w,
                                                  input int unsigned l);
  lane_word_t  lw;
  int unsigned s;
  int unsigned b;
  int unsigned e;
  int unsigned off;
  s        = insn_sew[seq];
  lw.id    = vid_t'(insn_id[seq]);
  lw.addr  = vaddr_t'(insn_vd[seq] * VRegWords + w);
  lw.wdata = '0;
  lw.be    = '0;
  for (int unsigned j = 0; j < WordBytes; j++) begin
    b   = w * WordBytes + j;
    e   = b >> s;
    off = (((e / NrLanes) << s) + (b % (1 << s))) % LaneBytes;
    // Past the end of the load nothing is written
    if (b < load_bytes(seq) && (e % NrLanes) == l) begin
      lw.wdata[8*off +: 8] = ref_bytes[seq][b];
      lw.be[off]           = 1'b1;
    end
  end
  return lw;
endfunction

function automatic elen_t byte_mask(input strb_t be);
  elen_t m;
  for (int i = 0; i < LaneBytes; i++) begin
    m[8*i +: 8] = {8{be[i]}};
  end
  return m;
endfunction

task automatic check_value(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("FAIL at %0d ns: %s got %0h expected %0h", $time, what, got, exp));
  end
endtask

`endif

//--- bench/tb_vldu.sv
//--------------------
// Loads are tracked by acceptance order; at most MaxInsn per run
// Inputs change on falling edges, outputs are sampled on rising edges
//--------------------
`timescale 1ns/1ps

module tb_vldu import vldu_pkg::*; ();

  localparam int unsigned WaitCycles = 3000;
  localparam int unsigned MaxInsn    = 32;

  logic                 clk_i;
  logic                 rst_ni;
  ld_req_t              pe_req_i;
  logic                 pe_req_valid_i;
  logic                 pe_req_ready_o;
  logic   [NrVInsn-1:0] vinsn_done_o;
  beat_t                r_data_i;
  logic                 r_valid_i;
  logic                 r_ready_o;
  logic   [NrLanes-1:0] ldu_req_o;
  vid_t   [NrLanes-1:0] ldu_id_o;
  vaddr_t [NrLanes-1:0] ldu_addr_o;
  elen_t  [NrLanes-1:0] ldu_wdata_o;
  strb_t  [NrLanes-1:0] ldu_be_o;
  logic   [NrLanes-1:0] ldu_gnt_i;

  // Reference tables, indexed by acceptance order
  logic [7:0]  ref_bytes [MaxInsn][MaxVlBytes];
  int unsigned insn_id   [MaxInsn];
  int unsigned insn_vd   [MaxInsn];
  int unsigned insn_vl   [MaxInsn];
  int unsigned insn_sew  [MaxInsn];
  int unsigned nr_accepted;
  int unsigned done_idx;
  // Next expected write per lane
  int unsigned lane_seq  [NrLanes];
  int unsigned lane_word [NrLanes];
  logic       [NrLanes-1:0] prev_req;
  logic       [NrLanes-1:0] prev_gnt;
  lane_word_t               prev_word [NrLanes];

  // Beat source state
  int unsigned beat_queue [$];
  logic        beats_on;
  logic        gaps_on;
  logic        grants_random;
  logic        beat_fire;
  logic        beat_busy;
  int unsigned beat_seq;
  int unsigned beat_idx;
  logic [15:0] stim_lfsr;
  logic [15:0] beat_lfsr;
  logic [15:0] gnt_lfsr;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

`include "tb_vldu_ref.svh"

  vldu vldu_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .vinsn_done_o   (vinsn_done_o),
    .r_data_i       (r_data_i),
    .r_valid_i      (r_valid_i),
    .r_ready_o      (r_ready_o),
    .ldu_req_o      (ldu_req_o),
    .ldu_id_o       (ldu_id_o),
    .ldu_addr_o     (ldu_addr_o),
    .ldu_wdata_o    (ldu_wdata_o),
    .ldu_be_o       (ldu_be_o),
    .ldu_gnt_i      (ldu_gnt_i)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // Lane grants, all high or one random bit per lane
  always @(negedge clk_i) begin : grant_drive
    logic [63:0] bits;
    if (grants_random) begin
      draw_bits(gnt_lfsr, NrLanes, bits);
      ldu_gnt_i = bits[NrLanes-1:0];
    end else begin
      ldu_gnt_i = '1;
    end
  end

  always @(posedge clk_i) beat_fire <= r_valid_i && r_ready_o;

  // Memory model: beats of each accepted load in order, bytes logged as sent
  always @(negedge clk_i) begin : beat_drive
    logic [63:0] bits;
    logic        gap;
    if (rst_ni) begin
      if (beat_fire) begin
        r_valid_i = 1'b0;
        beat_idx++;
        if (beat_idx == beat_count(beat_seq)) beat_busy = 1'b0;
      end
      if (!beat_busy && beats_on && beat_queue.size() != 0) begin
        beat_seq  = beat_queue.pop_front();
        beat_idx  = 0;
        beat_busy = 1'b1;
      end
      if (!r_valid_i && beat_busy && beats_on) begin
        gap = 1'b0;
        if (gaps_on) begin
          draw_bits(beat_lfsr, 1, bits);
          gap = bits[0];
        end
        if (!gap) begin
          draw_bits(beat_lfsr, 64, bits);
          r_data_i  = bits;
          r_valid_i = 1'b1;
          for (int i = 0; i < BeatBytes; i++) begin
            if (beat_idx * BeatBytes + i < MaxVlBytes)
              ref_bytes[beat_seq][beat_idx * BeatBytes + i] = bits[8*i +: 8];
          end
        end
      end
    end
  end

  // Compare lane writes, held requests and done pulses
  always @(posedge clk_i) begin : check_outputs
    lane_word_t got;
    lane_word_t exp;
    if (rst_ni) begin
      for (int l = 0; l < NrLanes; l++) begin
        got = '{id: ldu_id_o[l], addr: ldu_addr_o[l], wdata: ldu_wdata_o[l], be: ldu_be_o[l]};
        if (prev_req[l] && !prev_gnt[l]) begin
          check_value($sformatf("ldu_req_o[%0d] held", l), ldu_req_o[l], 1'b1);
          check_value($sformatf("lane %0d payload held", l), got, prev_word[l]);
        end
        if (ldu_req_o[l] && ldu_gnt_i[l]) begin
          if (lane_seq[l] >= nr_accepted) abort_run("Lane write with no load outstanding");
          exp = expected_lane_word(lane_seq[l], lane_word[l], l);
          check_value($sformatf("ldu_id_o[%0d]", l), got.id, exp.id);
          check_value($sformatf("ldu_addr_o[%0d]", l), got.addr, exp.addr);
          check_value($sformatf("ldu_be_o[%0d]", l), got.be, exp.be);
          check_value($sformatf("ldu_wdata_o[%0d]", l), got.wdata & byte_mask(got.be),
                      exp.wdata);
          lane_word[l]++;
          if (lane_word[l] == word_count(lane_seq[l])) begin
            lane_seq[l]++;
            lane_word[l] = 0;
          end
        end
        prev_req[l]  = ldu_req_o[l];
        prev_gnt[l]  = ldu_gnt_i[l];
        prev_word[l] = got;
      end
      if (vinsn_done_o != '0) begin
        if (done_idx >= nr_accepted) abort_run("Done pulse with no load outstanding");
        check_value("vinsn_done_o", vinsn_done_o, 1 << insn_id[done_idx]);
        // Every lane must have written the whole load
        for (int l = 0; l < NrLanes; l++) begin
          check_value($sformatf("lane %0d finished before done", l), lane_seq[l] > done_idx,
                      1'b1);
        end
        done_idx++;
      end
    end
  end

  // Caller sits on a falling edge
  task automatic present_req(input int unsigned id, input int unsigned vd,
                             input int unsigned vl, input vsew_e sew);
    insn_id[nr_accepted]  = id;
    insn_vd[nr_accepted]  = vd;
    insn_vl[nr_accepted]  = vl;
    insn_sew[nr_accepted] = sew;
    pe_req_i       = '{id: vid_t'(id), vd: vreg_t'(vd), vl: vlen_t'(vl), vsew: sew};
    pe_req_valid_i = 1'b1;
  endtask

  task automatic await_accept();
    int unsigned n;
    logic        accepted;
    n        = 0;
    accepted = 1'b0;
    while (!accepted && n < WaitCycles) begin
      @(posedge clk_i);
      accepted = pe_req_ready_o;
      n++;
    end
    if (!accepted) abort_run("Timeout waiting for pe_req_ready_o");
    beat_queue.push_back(nr_accepted);
    nr_accepted++;
    @(negedge clk_i);
    pe_req_valid_i = 1'b0;
  endtask

  task automatic send_req(input int unsigned id, input int unsigned vd,
                          input int unsigned vl, input vsew_e sew);
    present_req(id, vd, vl, sew);
    await_accept();
  endtask

  task automatic drain();
    int unsigned n;
    n = 0;
    while (done_idx != nr_accepted && n < WaitCycles) begin
      @(negedge clk_i);
      n++;
    end
    if (done_idx != nr_accepted) abort_run("Timeout waiting for done pulses");
  endtask

  // Request must be refused until beats flow and some load finishes
  task automatic stall_then_accept(input int unsigned id, input int unsigned vd,
                                   input int unsigned vl, input vsew_e sew,
                                   input int unsigned cycles);
    int unsigned base;
    base = done_idx;
    present_req(id, vd, vl, sew);
    for (int unsigned c = 0; c < cycles; c++) begin
      @(posedge clk_i);
      check_value("pe_req_ready_o while blocked", pe_req_ready_o, 1'b0);
    end
    beats_on = 1'b1;
    await_accept();
    check_value("done pulse before acceptance", done_idx > base, 1'b1);
  endtask

  initial begin : run_tests
    logic [63:0] sew_bits;
    logic [63:0] vl_bits;
    logic [63:0] vd_bits;
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    r_data_i       = '0;
    r_valid_i      = 1'b0;
    ldu_gnt_i      = '0;
    nr_accepted    = 0;
    done_idx       = 0;
    lane_seq       = '{default: 0};
    lane_word      = '{default: 0};
    prev_req       = '0;
    prev_gnt       = '0;
    beats_on       = 1'b1;
    gaps_on        = 1'b0;
    grants_random  = 1'b0;
    beat_busy      = 1'b0;
    beat_seq       = 0;
    beat_idx       = 0;
    stim_lfsr      = 16'd20764;
    beat_lfsr      = 16'd20764;
    gnt_lfsr       = 16'd20764;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("pe_req_ready_o after reset", pe_req_ready_o, 1'b0);
    check_value("r_ready_o after reset", r_ready_o, 1'b0);
    check_value("ldu_req_o after reset", ldu_req_o, '0);
    check_value("vinsn_done_o after reset", vinsn_done_o, '0);

    // EW64, two full words
    send_req(0, 1, 4, EW64);
    drain();
    // EW8 with a partial last word
    send_req(1, 2, 21, EW8);
    drain();
    // Back to back, mixed widths
    send_req(3, 4, 20, EW16);
    send_req(4, 5, 9, EW32);
    send_req(5, 6, 13, EW16);
    drain();

    // Random grants and beat gaps
    gaps_on       = 1'b1;
    grants_random = 1'b1;
    for (int unsigned i = 0; i < 6; i++) begin
      draw_bits(stim_lfsr, 2, sew_bits);
      draw_bits(stim_lfsr, 5, vl_bits);
      draw_bits(stim_lfsr, 5, vd_bits);
      send_req(i, vd_bits[4:0], vl_bits[4:0] + 1, vsew_e'(sew_bits[1:0]));
    end
    drain();

    // Full instruction queue with no beats
    beats_on = 1'b0;
    for (int unsigned i = 0; i < VInsnQueueDepth; i++) begin
      send_req(i, 8 + i, 16, EW32);
    end
    stall_then_accept(6, 12, 8, EW8, 12);
    drain();

    // Reused id while it still runs
    beats_on = 1'b0;
    send_req(2, 20, 64, EW32);
    stall_then_accept(2, 21, 5, EW64, 12);
    drain();

    if (done_idx == nr_accepted && lane_seq[0] == nr_accepted &&
        lane_seq[1] == nr_accepted) begin
      $display(">>> PASS");
    end else begin
      abort_run("Loads left unfinished at end of run");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
hdl/vldu_pkg.sv
hdl/vldu_ring_fifo.sv
hdl/vldu_insn_tracker.sv
hdl/vldu_beat_packer.sv
hdl/vldu_result_queue.sv
hdl/vldu.sv
bench/tb_vldu.sv
